//--- player_pkg.sv
package player_pkg;

  // ========================================
  // Flash word layout
  // ========================================

  localparam int FLASH_WORD_W = 32;
  localparam int SAMPLE_W = 16;
  localparam int WORD_ADDR_W = 23;

  // Two audio samples per flash word, low half played first going forward
  localparam int SAMPLES_PER_WORD = 2;

  typedef logic [FLASH_WORD_W-1:0] flash_word_t;

  // ========================================
  // Audio and addressing
  // ========================================

  // Signed PCM sample as stored in flash
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // Word address, not byte address
  typedef logic [WORD_ADDR_W-1:0] word_addr_t;

endpackage

//--- kbd_pkg.sv
package kbd_pkg;

  // One ASCII character from the keyboard port
  typedef logic [7:0] ascii_t;

  // ========================================
  // Player command keys
  // ========================================

  // Start playback
  localparam ascii_t KEY_PLAY_U = 8'h45;
  localparam ascii_t KEY_PLAY_L = 8'h65;

  // Pause
  localparam ascii_t KEY_PAUSE_U = 8'h44;
  localparam ascii_t KEY_PAUSE_L = 8'h64;

  // Direction select
  localparam ascii_t KEY_FWD_U = 8'h46;
  localparam ascii_t KEY_FWD_L = 8'h66;
  localparam ascii_t KEY_BWD_U = 8'h42;
  localparam ascii_t KEY_BWD_L = 8'h62;

  // Jump back to the start of the song
  localparam ascii_t KEY_RESTART_U = 8'h52;
  localparam ascii_t KEY_RESTART_L = 8'h72;

endpackage

//--- kbd_command_decoder.sv
module kbd_command_decoder
  import kbd_pkg::*;
(
  input  logic   CLK_50M,
  input  logic   rst_n,
  input  logic   kbd_valid,
  input  ascii_t kbd_byte,
  output logic   kbd_ready,
  output logic   play,
  output logic   reverse,
  output logic   restart
);

  logic kbd_accept;
  logic is_restart;

  assign kbd_accept = kbd_valid && kbd_ready;

  // Both cases of R request a restart
  assign is_restart = (kbd_byte == KEY_RESTART_U) || (kbd_byte == KEY_RESTART_L);

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      kbd_ready <= 1'b0;
      play      <= 1'b0;
      reverse   <= 1'b0;
      restart   <= 1'b0;
    end
    else
    begin
      // Always ready once out of reset
      kbd_ready <= 1'b1;

      // Back-to-back R bytes merge into one pulse
      restart <= kbd_accept && is_restart && !restart;

      if (kbd_accept)
      begin
        case (kbd_byte)
          KEY_PLAY_U, KEY_PLAY_L:   play    <= 1'b1;
          KEY_PAUSE_U, KEY_PAUSE_L: play    <= 1'b0;
          KEY_FWD_U, KEY_FWD_L:     reverse <= 1'b0;
          KEY_BWD_U, KEY_BWD_L:     reverse <= 1'b1;
          default:
          begin
            // Unknown byte, nothing changes
          end
        endcase
      end
    end
  end

  // Reader treats restart as an event, never a level
  a_restart_single: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    restart |=> !restart
  ) else $error("restart held high for two cycles");

endmodule

//--- sample_rate_gen.sv
module sample_rate_gen #(
  parameter logic [15:0] DEFAULT_PERIOD = 16'd2268,
  parameter logic [15:0] PERIOD_STEP    = 16'd128,
  parameter logic [15:0] MIN_PERIOD     = 16'd1024,
  parameter logic [15:0] MAX_PERIOD     = 16'd8192
) (
  input  logic CLK_50M,
  input  logic rst_n,
  input  logic speed_up,
  input  logic speed_down,
  input  logic speed_reset,
  output logic sample_tick
);

  logic [15:0] period;
  logic [15:0] count;
  logic [16:0] count_next;
  logic [16:0] faster;
  logic [16:0] slower;
  logic        faster_ok;
  logic        slower_ok;
  logic        period_done;

  // ========================================
  // Period register
  // ========================================

  // Extra bit catches underflow and overflow of the step
  assign faster = {1'b0, period} - {1'b0, PERIOD_STEP};
  assign slower = {1'b0, period} + {1'b0, PERIOD_STEP};

  assign faster_ok = !faster[16] && (faster[15:0] >= MIN_PERIOD);
  assign slower_ok = slower <= {1'b0, MAX_PERIOD};

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
      period <= DEFAULT_PERIOD;
    else if (speed_reset)
      period <= DEFAULT_PERIOD;
    else if (speed_up && faster_ok)
      period <= faster[15:0];
    else if (speed_down && slower_ok)
      period <= slower[15:0];
  end

  // ========================================
  // Divider
  // ========================================

  // Greater-or-equal so a shortened period still ends the count
  assign count_next  = {1'b0, count} + 17'd1;
  assign period_done = count_next >= {1'b0, period};

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count       <= '0;
      sample_tick <= 1'b0;
    end
    else
    begin
      sample_tick <= period_done;
      count       <= period_done ? '0 : count_next[15:0];
    end
  end

  a_period_range: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    (period >= MIN_PERIOD) && (period <= MAX_PERIOD)
  ) else $error("sample period %0d out of range", period);

endmodule

//--- flash_reader.sv
module flash_reader
  import player_pkg::*;
#(
  parameter word_addr_t LAST_ADDR = 23'h7FFFF
) (
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  logic        play,
  input  logic        reverse,
  input  logic        restart,
  input  logic        sample_tick,
  input  logic        flash_waitrequest,
  input  logic        flash_readdatavalid,
  input  flash_word_t flash_readdata,
  input  logic        sample_ready,
  output logic        flash_read,
  output word_addr_t  flash_addr,
  output logic        sample_valid,
  output sample_t     sample_data
);

  localparam int HALF_W = $clog2(SAMPLES_PER_WORD);

  localparam logic [1:0] RD_IDLE = 2'd0;
  localparam logic [1:0] RD_REQ  = 2'd1;
  localparam logic [1:0] RD_WAIT = 2'd2;

  logic [1:0]        rd_state;
  word_addr_t        addr;
  word_addr_t        next_addr;
  flash_word_t       word_buf;
  logic              word_valid;
  logic [HALF_W-1:0] half_sel;
  logic [HALF_W-1:0] first_half;
  logic              discard;
  logic              read_busy;
  logic              start_ok;
  logic              start_read;
  logic              take_second;
  logic              word_ret;

  // ========================================
  // Playing order
  // ========================================

  // Forward plays low half first, backward the high half
  assign first_half = reverse ? HALF_W'(SAMPLES_PER_WORD - 1) : '0;

  always_comb
  begin
    if (reverse)
      next_addr = (addr == '0) ? LAST_ADDR : addr - 1'b1;
    else
      next_addr = (addr == LAST_ADDR) ? '0 : addr + 1'b1;
  end

  // A tick only starts work when nothing is pending or in flight
  assign start_ok    = sample_tick && play && !sample_valid && (rd_state == RD_IDLE)
                       && !restart;
  assign take_second = start_ok && word_valid;
  assign start_read  = start_ok && !word_valid;

  // Word for the old position is dropped after a restart
  assign word_ret  = (rd_state == RD_WAIT) && flash_readdatavalid && !discard && !restart;
  assign read_busy = (rd_state == RD_REQ) || ((rd_state == RD_WAIT) && !flash_readdatavalid);

  // ========================================
  // Control and read FSM
  // ========================================

  always_ff @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rd_state     <= RD_IDLE;
      flash_read   <= 1'b0;
      flash_addr   <= '0;
      addr         <= '0;
      word_valid   <= 1'b0;
      half_sel     <= '0;
      discard      <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      if (sample_valid && sample_ready)
        sample_valid <= 1'b0;

      case (rd_state)
        RD_IDLE:
        begin
          if (start_read)
          begin
            rd_state   <= RD_REQ;
            flash_read <= 1'b1;
            flash_addr <= addr;
          end
        end
        RD_REQ:
        begin
          // Held until the memory stops stalling
          if (!flash_waitrequest)
          begin
            rd_state   <= RD_WAIT;
            flash_read <= 1'b0;
          end
        end
        RD_WAIT:
        begin
          if (flash_readdatavalid)
          begin
            rd_state <= RD_IDLE;
            discard  <= 1'b0;
          end
        end
        default: rd_state <= RD_IDLE;
      endcase

      if (word_ret)
      begin
        sample_valid <= 1'b1;
        word_valid   <= 1'b1;
        half_sel     <= ~first_half;
      end

      // Second half used up, so the word is done
      if (take_second)
      begin
        sample_valid <= 1'b1;
        word_valid   <= 1'b0;
        addr         <= next_addr;
      end

      if (restart)
      begin
        addr       <= reverse ? LAST_ADDR : '0;
        word_valid <= 1'b0;
        discard    <= read_busy;
      end
    end
  end

  // ========================================
  // Payload
  // ========================================

  always_ff @(posedge CLK_50M)
  begin
    if (word_ret)
    begin
      word_buf    <= flash_readdata;
      sample_data <= flash_readdata[first_half*SAMPLE_W +: SAMPLE_W];
    end
    else if (take_second)
      sample_data <= word_buf[half_sel*SAMPLE_W +: SAMPLE_W];
  end

  a_flash_hold: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    flash_read && flash_waitrequest |=> flash_read && $stable(flash_addr)
  ) else $error("flash request changed while stalled");

  a_sample_hold: assert property (
    @(posedge CLK_50M) disable iff (!rst_n)
    sample_valid && !sample_ready |=> sample_valid && $stable(sample_data)
  ) else $error("sample changed before it was taken");

endmodule

//--- ipod_player_top.sv
module ipod_player_top
  import player_pkg::*;
  import kbd_pkg::*;
#(
  parameter word_addr_t  LAST_ADDR      = 23'h7FFFF,
  parameter logic [15:0] DEFAULT_PERIOD = 16'd2268,
  parameter logic [15:0] PERIOD_STEP    = 16'd128,
  parameter logic [15:0] MIN_PERIOD     = 16'd1024,
  parameter logic [15:0] MAX_PERIOD     = 16'd8192
) (
  input  logic        CLK_50M,
  input  logic        rst_n,
  input  logic        kbd_valid,
  input  ascii_t      kbd_byte,
  input  logic        speed_up,
  input  logic        speed_down,
  input  logic        speed_reset,
  input  logic        flash_waitrequest,
  input  logic        flash_readdatavalid,
  input  flash_word_t flash_readdata,
  input  logic        sample_ready,
  output logic        kbd_ready,
  output logic        flash_read,
  output word_addr_t  flash_addr,
  output logic        sample_valid,
  output sample_t     sample_data
);

  logic play;
  logic reverse;
  logic restart;
  logic sample_tick;

  kbd_command_decoder u_kbd_command_decoder (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .kbd_valid (kbd_valid),
    .kbd_byte  (kbd_byte),
    .kbd_ready (kbd_ready),
    .play      (play),
    .reverse   (reverse),
    .restart   (restart)
  );

  sample_rate_gen #(
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .PERIOD_STEP    (PERIOD_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD)
  ) u_sample_rate_gen (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .sample_tick (sample_tick)
  );

  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) u_flash_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .play                (play),
    .reverse             (reverse),
    .restart             (restart),
    .sample_tick         (sample_tick),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .sample_ready        (sample_ready),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .sample_valid        (sample_valid),
    .sample_data         (sample_data)
  );

endmodule

//--- tb_clock_gen.sv
module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 10
) (
  output logic CLK_50M,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    CLK_50M = 1'b0;
    forever #HALF_PERIOD CLK_50M = ~CLK_50M;
  end

  // Reset released on a rising edge
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK_50M);
    rst_n <= 1'b1;
  end

endmodule

//--- tb_ipod_player.sv
module tb_ipod_player
  import player_pkg::*;
  import kbd_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam word_addr_t  LAST_ADDR      = 23'd7;
  localparam logic [15:0] DEFAULT_PERIOD = 16'd40;
  localparam logic [15:0] PERIOD_STEP    = 16'd8;
  localparam logic [15:0] MIN_PERIOD     = 16'd24;
  localparam logic [15:0] MAX_PERIOD     = 16'd56;
  localparam int          QUIET_CYCLES   = 3 * MAX_PERIOD;
  localparam int          STALL_CYCLES   = 100;

  logic        CLK_50M;
  logic        rst_n;
  logic        kbd_valid;
  ascii_t      kbd_byte;
  logic        kbd_ready;
  logic        speed_up;
  logic        speed_down;
  logic        speed_reset;
  logic        flash_read;
  word_addr_t  flash_addr;
  logic        flash_waitrequest   = 1'b0;
  logic        flash_readdatavalid = 1'b0;
  flash_word_t flash_readdata      = '0;
  logic        sample_ready;
  logic        sample_valid;
  sample_t     sample_data;

  int          rec_kind[$];
  int          rec_a[$];
  int          rec_b[$];
  int          rec_c[$];
  int          rec_d[$];
  logic        loaded = 1'b0;
  int          cycles = 0;
  logic [15:0] exp_period = DEFAULT_PERIOD;
  int          sample_errors = 0;
  int          interval_errors = 0;
  int          other_errors = 0;

  logic [31:0] rnd_state;
  logic [31:0] rnd_next;
  logic [1:0]  stall_left;

  tb_clock_gen u_tb_clock_gen (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n)
  );

  ipod_player_top #(
    .LAST_ADDR      (LAST_ADDR),
    .DEFAULT_PERIOD (DEFAULT_PERIOD),
    .PERIOD_STEP    (PERIOD_STEP),
    .MIN_PERIOD     (MIN_PERIOD),
    .MAX_PERIOD     (MAX_PERIOD)
  ) u_ipod_player_top (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .kbd_valid           (kbd_valid),
    .kbd_byte            (kbd_byte),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .sample_ready        (sample_ready),
    .kbd_ready           (kbd_ready),
    .flash_read          (flash_read),
    .flash_addr          (flash_addr),
    .sample_valid        (sample_valid),
    .sample_data         (sample_data)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Low half is 32a+1, high half 32a+2
  function automatic sample_t flash_half(input word_addr_t addr, input bit high);
    return sample_t'(addr * 32 + (high ? 2 : 1));
  endfunction

  // ========================================
  // Flash model
  // ========================================

  assign rnd_next = xorshift(rnd_state);

  always @(posedge CLK_50M or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rnd_state           <= 32'd17;
      stall_left          <= 2'd0;
      flash_waitrequest   <= 1'b0;
      flash_readdatavalid <= 1'b0;
    end
    else
    begin
      flash_readdatavalid <= 1'b0;
      if (flash_read && !flash_waitrequest)
      begin
        // Accepted here, data one cycle later, stall drawn for the next read
        flash_readdatavalid <= 1'b1;
        flash_readdata      <= {flash_half(flash_addr, 1'b1), flash_half(flash_addr, 1'b0)};
        rnd_state           <= rnd_next;
        stall_left          <= rnd_next[1:0];
        flash_waitrequest   <= (rnd_next[1:0] != 2'd0);
      end
      else if (flash_read && flash_waitrequest)
      begin
        stall_left        <= stall_left - 2'd1;
        flash_waitrequest <= (stall_left > 2'd1);
      end
    end
  end

  always @(posedge CLK_50M)
    cycles <= cycles + 1;

  // ========================================
  // Checks
  // ========================================

  task automatic check_sample(input string name, input sample_t expected, input sample_t actual);
    if (actual !== expected)
    begin
      sample_errors++;
      $display("FAILED at %0d ns: %s expected %0d, actual %0d", $time, name, expected, actual);
    end
  endtask

  task automatic check_interval(input string name, input logic [15:0] expected,
                                input logic [15:0] actual);
    // Read latency jitter allowed for
    if ((actual > expected + 16'd5) || (actual + 16'd5 < expected))
    begin
      interval_errors++;
      $display("FAILED at %0d ns: %s expected %0d, actual %0d", $time, name, expected, actual);
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================

  task automatic load_records();
    int fd;
    int n;
    int kind;
    int a;
    int b;
    int c;
    int d;
    logic [8*120-1:0] line;
    fd = $fopen("player_stimulus.txt", "r");
    if (fd == 0)
    begin
      other_errors++;
      $display("Error: could not open player_stimulus.txt");
      return;
    end
    while (!$feof(fd))
    begin
      if ($fgets(line, fd) != 0)
      begin
        n = $sscanf(line, "%h %h %h %h %h", kind, a, b, c, d);
        // Comment and blank lines do not scan
        if (n == 5)
        begin
          rec_kind.push_back(kind);
          rec_a.push_back(a);
          rec_b.push_back(b);
          rec_c.push_back(c);
          rec_d.push_back(d);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic send_command(input ascii_t code);
    @(posedge CLK_50M);
    kbd_valid <= 1'b1;
    kbd_byte  <= code;
    do
      @(negedge CLK_50M);
    while (!kbd_ready);
    @(posedge CLK_50M);
    kbd_valid <= 1'b0;
  endtask

  task automatic pulse_speed(input int kind, input int pulses);
    int n;
    for (n = 0; n < pulses; n++)
    begin
      @(posedge CLK_50M);
      case (kind)
        1: speed_up <= 1'b1;
        2: speed_down <= 1'b1;
        3: speed_reset <= 1'b1;
        default:
        begin
          other_errors++;
          $display("Error: unknown speed event %0d in stimulus", kind);
        end
      endcase
      @(posedge CLK_50M);
      speed_up    <= 1'b0;
      speed_down  <= 1'b0;
      speed_reset <= 1'b0;
      // Period follows the clamping rule
      if (kind == 3)
        exp_period = DEFAULT_PERIOD;
      else if (kind == 1 && exp_period >= MIN_PERIOD + PERIOD_STEP)
        exp_period = exp_period - PERIOD_STEP;
      else if (kind == 2 && exp_period + PERIOD_STEP <= MAX_PERIOD)
        exp_period = exp_period + PERIOD_STEP;
    end
  endtask

  task automatic expect_no_samples();
    bit seen;
    seen = 1'b0;
    repeat (QUIET_CYCLES)
    begin
      @(negedge CLK_50M);
      if (sample_valid && !seen)
      begin
        seen = 1'b1;
        other_errors++;
        $display("Error at %0d ns: a sample appeared while playback was stopped", $time);
      end
    end
  endtask

  task automatic play_samples(input int count, input sample_t first, input bit backward,
                              input int mode);
    word_addr_t addr;
    bit         high;
    sample_t    expected;
    sample_t    held;
    int         i;
    int         t_start;
    int         t_end;
    addr    = word_addr_t'(first[15:5]);
    high    = (first[4:0] == 5'd2);
    t_start = 0;
    t_end   = 0;
    if (mode == 2)
    begin
      @(posedge CLK_50M);
      sample_ready <= 1'b0;
    end
    for (i = 0; i < count; i++)
    begin
      expected = (i == 0) ? first : flash_half(addr, high);
      do
        @(negedge CLK_50M);
      while (!sample_valid);
      if (mode == 2 && i == 0)
      begin
        // Back-pressure on the first sample
        held = sample_data;
        repeat (STALL_CYCLES)
        begin
          @(negedge CLK_50M);
          if (!sample_valid)
          begin
            other_errors++;
            $display("Error at %0d ns: sample_valid dropped while sample_ready low", $time);
          end
          check_sample("sample_data", held, sample_data);
        end
        @(posedge CLK_50M);
        sample_ready <= 1'b1;
        @(negedge CLK_50M);
      end
      check_sample("sample_data", expected, sample_data);
      if (i == 1)
        t_start = cycles;
      if (i == 9)
        t_end = cycles;
      // Step to the next half in playing order, song wraps modulo LAST_ADDR+1 words
      if (!backward && !high)
        high = 1'b1;
      else if (!backward)
      begin
        high = 1'b0;
        addr = word_addr_t'((int'(addr) + 1) % (int'(LAST_ADDR) + 1));
      end
      else if (high)
        high = 1'b0;
      else
      begin
        high = 1'b1;
        addr = word_addr_t'((int'(addr) + int'(LAST_ADDR)) % (int'(LAST_ADDR) + 1));
      end
    end
    if (mode == 1 && count >= 10)
      check_interval("sample interval", exp_period, 16'((t_end - t_start) / 8));
  endtask

  // ========================================
  // Main sequence
  // ========================================

  initial
  begin
    int i;
    kbd_valid    = 1'b0;
    kbd_byte     = '0;
    speed_up     = 1'b0;
    speed_down   = 1'b0;
    speed_reset  = 1'b0;
    sample_ready = 1'b1;
    load_records();
    if (rec_kind.size() > 0)
      loaded = 1'b1;
    else
    begin
      other_errors++;
      $display("Error: no records found in player_stimulus.txt");
    end
    wait (rst_n === 1'b1);
    @(posedge CLK_50M);
    for (i = 0; i < rec_kind.size(); i++)
    begin
      case (rec_kind[i])
        1: send_command(ascii_t'(rec_a[i]));
        2: pulse_speed(rec_a[i], rec_b[i]);
        3:
        begin
          if (rec_a[i] == 0)
            expect_no_samples();
          else
            play_samples(rec_a[i], sample_t'(rec_b[i]), rec_c[i] != 0, rec_d[i]);
        end
        default:
        begin
          other_errors++;
          $display("Error: record %0d has unknown kind %0d", i, rec_kind[i]);
        end
      endcase
    end
    repeat (4) @(posedge CLK_50M);
    $display("Errors: %0d sample, %0d interval, %0d other",
             sample_errors, interval_errors, other_errors);
    if (sample_errors + interval_errors + other_errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  // Limit scales with the number of records
  initial
  begin
    int limit;
    wait (loaded);
    limit = rec_kind.size() * MAX_PERIOD * 40;
    repeat (limit) @(posedge CLK_50M);
    $display("Watchdog expired after %0d cycles, the test did not finish", limit);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

//--- player_stimulus.txt
# Columns in hex: kind a b c d. Kind 1 sends command byte a. Kind 2 pulses speed event a
# (1 up, 2 down, 3 reset) b times. Kind 3 expects a samples from first sample b, backward if
# c is 1, mode d (0 plain, 1 interval check, 2 sample_ready held low); a of 0 expects none
3 0 0 0 0
1 45 0 0 0
3 14 1 0 1
1 42 0 0 0
3 8 42 1 0
3 3 c2 1 0
1 72 0 0 0
3 4 e2 1 0
1 46 0 0 0
1 52 0 0 0
3 6 1 0 0
2 1 3 0 0
3 a 61 0 1
2 2 5 0 0
3 a 1 0 1
2 3 1 0 0
3 a a1 0 1
1 44 0 0 0
1 5a 0 0 0
1 31 0 0 0
3 0 0 0 0
1 65 0 0 0
3 4 41 0 0
3 6 81 0 2

//--- vlog.f
player_pkg.sv
kbd_pkg.sv
kbd_command_decoder.sv
sample_rate_gen.sv
flash_reader.sv
ipod_player_top.sv
tb_clock_gen.sv
tb_ipod_player.sv

//--- Bender.yml
package:
  name: ipod_player

sources:
  - player_pkg.sv
  - kbd_pkg.sv
  - kbd_command_decoder.sv
  - sample_rate_gen.sv
  - flash_reader.sv
  - ipod_player_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_ipod_player.sv
